// ==== verilog/fm_acc_pkg.sv ====
package fm_acc_pkg;

	// chip constants
	localparam int num_ch          = 6;
	localparam int op_w            = 9;
	localparam int mix_w           = 12;
	localparam int slots_per_frame = 24;

	// phases in the order the slots run
	typedef enum logic [1:0] {
		ph_s1 = 2'd0,
		ph_s3 = 2'd1,
		ph_s2 = 2'd2,
		ph_s4 = 2'd3
	} fm_phase_t;

	// one operator slot
	typedef struct packed {
		fm_phase_t  phase;
		logic [2:0] ch;
		// set on the sixth channel
		logic       ch6op;
	} fm_slot_t;

	// fm layout of a channel word
	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] alg;
		logic       spare;
		logic       limiter_en;
		logic       pcm_mode;
	} fm_fm_cfg_t;

	// pcm layout, sample itself comes on the pcm port
	typedef struct packed {
		logic [1:0] rl;
		logic [3:0] unused;
		logic       limiter_en;
		logic       pcm_mode;
	} fm_pcm_cfg_t;

	// pcm_mode is bit 0 in both views
	typedef union packed {
		fm_fm_cfg_t  fm;
		fm_pcm_cfg_t pcm;
	} fm_cfg_u;

	// per slot controls out of decode
	typedef struct packed {
		logic       sum_en;
		logic [1:0] rl;
		logic       limiter_en;
		logic       pcm_sel;
		// ph_s3 slot, channel sum restarts
		logic       first;
	} fm_ctl_t;

endpackage

// ==== verilog/fm_shift_ring.sv ====
module fm_shift_ring (
	input  logic                                  clk,
	input  logic                                  clk_en,
	input  logic signed [fm_acc_pkg::op_w-1:0]    din,
	output logic signed [fm_acc_pkg::op_w-1:0]    dout
);
	import fm_acc_pkg::*;

	// one stage per channel
	logic signed [op_w-1:0] stages [num_ch];

	always_ff @(posedge clk) begin
		if (clk_en) begin
			stages[0] <= din;
			// value comes back after a full round of channels
			for (int i = 1; i < num_ch; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	// oldest stage is the channel now in its slot
	assign dout = stages[num_ch-1];

endmodule

// ==== verilog/fm_slot_sequencer.sv ====
module fm_slot_sequencer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clk_en,
	output fm_acc_pkg::fm_slot_t  slot,
	output logic                  frame_start
);
	import fm_acc_pkg::*;

	// slot number within the frame, 0 to 23
	logic [4:0] cnt;
	// first slot of the current phase
	logic [4:0] base;
	logic [4:0] offs;
	fm_phase_t  phase;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (clk_en) begin
			// wrap after the last s4 slot
			if (cnt == 5'(slots_per_frame - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 5'd1;
			end
		end
	end

	// six channels per phase
	always_comb begin
		if (cnt < 5'(num_ch)) begin
			phase = ph_s1;
			base  = 5'd0;
		end else if (cnt < 5'(2 * num_ch)) begin
			phase = ph_s3;
			base  = 5'(num_ch);
		end else if (cnt < 5'(3 * num_ch)) begin
			phase = ph_s2;
			base  = 5'(2 * num_ch);
		end else begin
			phase = ph_s4;
			base  = 5'(3 * num_ch);
		end
		offs = cnt - base;
	end

	assign slot.phase = phase;
	assign slot.ch    = offs[2:0];
	// channel 6 is number 5
	assign slot.ch6op = (offs[2:0] == 3'(num_ch - 1));

	assign frame_start = (cnt == '0);

endmodule

// ==== verilog/fm_sum_decode.sv ====
module fm_sum_decode (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clk_en,
	input  logic                  cfg_we,
	input  logic [2:0]            cfg_ch,
	input  fm_acc_pkg::fm_cfg_u   cfg_data,
	input  fm_acc_pkg::fm_slot_t  slot,
	output fm_acc_pkg::fm_ctl_t   ctl,
	output fm_acc_pkg::fm_slot_t  slot_out
);
	import fm_acc_pkg::*;

	// one config word per channel
	fm_cfg_u cfg_q [num_ch];
	fm_cfg_u word;

	// host writes land on every clock edge whether enabled or not
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_ch; i++) begin
				cfg_q[i] <= '0;
			end
		end else if (cfg_we && (cfg_ch < 3'(num_ch))) begin
			cfg_q[cfg_ch] <= cfg_data;
		end
	end

	// word of the channel in its slot
	assign word = cfg_q[slot.ch];

	always_comb begin
		ctl       = '0;
		ctl.first = (slot.phase == ph_s3);
		// pcm only honored on channel 6
		ctl.pcm_sel = slot.ch6op && word.pcm.pcm_mode;
		if (ctl.pcm_sel) begin
			// pcm view sums no operator
			ctl.rl         = word.pcm.rl;
			ctl.limiter_en = word.pcm.limiter_en;
			ctl.sum_en     = 1'b0;
		end else begin
			ctl.rl         = word.fm.rl;
			ctl.limiter_en = word.fm.limiter_en;
			// carrier operators per algorithm
			case (word.fm.alg)
				3'd4:       ctl.sum_en = (slot.phase == ph_s2) || (slot.phase == ph_s4);
				3'd5, 3'd6: ctl.sum_en = (slot.phase != ph_s1);
				3'd7:       ctl.sum_en = 1'b1;
				// algorithms 0 to 3 sum only the last operator
				default:    ctl.sum_en = (slot.phase == ph_s4);
			endcase
		end
	end

	// slot passes through unchanged
	assign slot_out = slot;

endmodule

// ==== verilog/fm_channel_acc.sv ====
module fm_channel_acc (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               clk_en,
	input  fm_acc_pkg::fm_slot_t               slot,
	input  fm_acc_pkg::fm_ctl_t                ctl,
	input  logic signed [8:0]                  op_result,
	input  logic [8:0]                         pcm,
	output logic signed [8:0]                  ch_done,
	output logic [1:0]                         rl_done,
	output fm_acc_pkg::fm_slot_t               slot_out
);
	import fm_acc_pkg::*;

	// running channel sum, comes back at the channel's next slot
	logic signed [op_w-1:0] total;
	logic signed [op_w-1:0] opsum;
	logic signed [op_w-1:0] next_op;
	// one extra bit to catch overflow
	logic signed [op_w:0]   opsum10;
	logic signed [op_w-1:0] done_in;
	logic signed [op_w-1:0] done_out;
	// pan captured with the finished sum
	logic [1:0]             pan_mem [num_ch];

	// operators outside the algorithm's carriers count as zero
	assign next_op = ctl.sum_en ? op_result : '0;
	assign opsum10 = {next_op[op_w-1], next_op} + {total[op_w-1], total};

	always_comb begin
		if (ctl.first) begin
			// fresh sum, pcm is offset binary so flip the msb
			if (ctl.pcm_sel) begin
				opsum = {~pcm[8], pcm[7:0]};
			end else begin
				opsum = next_op;
			end
		end else if (ctl.sum_en) begin
			if (ctl.limiter_en && (opsum10[op_w] != opsum10[op_w-1])) begin
				// clamp to -256 or 255
				opsum = opsum10[op_w] ? 9'sh100 : 9'sh0ff;
			end else begin
				// tenth bit dropped, value wraps
				opsum = opsum10[op_w-1:0];
			end
		end else begin
			opsum = total;
		end
	end

	fm_shift_ring sum_ring_inst (
		.clk    (clk),
		.clk_en (clk_en),
		.din    (opsum),
		.dout   (total)
	);

	// at the first slot total holds last frame's finished sum
	assign done_in = ctl.first ? total : done_out;

	fm_shift_ring done_ring_inst (
		.clk    (clk),
		.clk_en (clk_en),
		.din    (done_in),
		.dout   (done_out)
	);

	// pan stored per channel next to the done value
	always_ff @(posedge clk) begin
		if (clk_en && !rst && ctl.first) begin
			pan_mem[slot.ch] <= ctl.rl;
		end
	end

	// s3 slots hand over the fresh value directly
	assign ch_done = done_in;
	assign rl_done = ctl.first ? ctl.rl : pan_mem[slot.ch];

	assign slot_out = slot;

endmodule

// ==== verilog/fm_output_mixer.sv ====
module fm_output_mixer (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   clk_en,
	input  fm_acc_pkg::fm_slot_t                   slot,
	input  logic signed [fm_acc_pkg::op_w-1:0]     ch_done,
	input  logic [1:0]                             rl_done,
	output logic signed [fm_acc_pkg::mix_w-1:0]    left,
	output logic signed [fm_acc_pkg::mix_w-1:0]    right,
	output logic                                   sample,
	output logic [fm_acc_pkg::op_w-1:0]            mux_left,
	output logic [fm_acc_pkg::op_w-1:0]            mux_right,
	output logic                                   mux_sample
);
	import fm_acc_pkg::*;

	logic signed [mix_w-1:0] ext;
	logic signed [mix_w-1:0] add_l;
	logic signed [mix_w-1:0] add_r;
	logic signed [mix_w-1:0] pre_left;
	logic signed [mix_w-1:0] pre_right;
	// completed frames since reset, stops at 2
	logic [1:0]              warm;
	logic                    last_slot;
	logic                    s3_first;
	logic                    s2_first;
	logic [1:0]              mux_cnt;
	// previous slot, so the mux visits every channel
	logic signed [op_w-1:0]  prev_done;
	logic [1:0]              prev_rl;
	logic signed [op_w-1:0]  pick_done;
	logic [1:0]              pick_rl;
	logic                    use_prev;

	assign ext   = {{(mix_w - op_w){ch_done[op_w-1]}}, ch_done};
	assign add_l = rl_done[1] ? ext : '0;
	assign add_r = rl_done[0] ? ext : '0;

	assign last_slot = (slot.phase == ph_s4) && slot.ch6op;
	assign s3_first  = (slot.phase == ph_s3) && (slot.ch == 3'd0);
	assign s2_first  = (slot.phase == ph_s2) && (slot.ch == 3'd0);

	// slots 3 and 7 and 11 fall in s1 or s3, step back one channel there
	assign use_prev  = (slot.phase == ph_s1) || (slot.phase == ph_s3);
	assign pick_done = use_prev ? prev_done : ch_done;
	assign pick_rl   = use_prev ? prev_rl : rl_done;

	// stereo sum over the s3 phase
	always_ff @(posedge clk) begin
		if (clk_en && (slot.phase == ph_s3)) begin
			if (s3_first) begin
				pre_left  <= add_l;
				pre_right <= add_r;
			end else begin
				pre_left  <= pre_left + add_l;
				pre_right <= pre_right + add_r;
			end
		end
		if (clk_en) begin
			prev_done <= ch_done;
			prev_rl   <= rl_done;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			left       <= '0;
			right      <= '0;
			sample     <= 1'b0;
			mux_left   <= '0;
			mux_right  <= '0;
			mux_sample <= 1'b0;
			mux_cnt    <= '0;
			warm       <= '0;
		end else begin
			// pulses last one clock
			sample     <= 1'b0;
			mux_sample <= 1'b0;
			if (clk_en) begin
				if (last_slot && (warm != 2'd2)) begin
					warm <= warm + 2'd1;
				end
				// first frame after reset holds no valid sums
				if (s2_first && (warm != 2'd0)) begin
					left   <= pre_left;
					right  <= pre_right;
					sample <= 1'b1;
				end
				mux_cnt <= mux_cnt + 2'd1;
				// done ring settles one frame later
				if ((mux_cnt == 2'd3) && (warm == 2'd2)) begin
					mux_left   <= pick_rl[1] ? pick_done : '0;
					mux_right  <= pick_rl[0] ? pick_done : '0;
					mux_sample <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== verilog/fm_acc_top.sv ====
module fm_acc_top (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  clk_en,
	input  logic signed [fm_acc_pkg::op_w-1:0]    op_result,
	input  logic [fm_acc_pkg::op_w-1:0]           pcm,
	input  logic                                  cfg_we,
	input  logic [2:0]                            cfg_ch,
	input  fm_acc_pkg::fm_cfg_u                   cfg_data,
	output logic signed [fm_acc_pkg::mix_w-1:0]   left,
	output logic signed [fm_acc_pkg::mix_w-1:0]   right,
	output logic                                  sample,
	output logic [fm_acc_pkg::op_w-1:0]           mux_left,
	output logic [fm_acc_pkg::op_w-1:0]           mux_right,
	output logic                                  mux_sample
);
	import fm_acc_pkg::*;

	// sequencer to decode
	fm_slot_t               seq_slot;
	// decode to execute
	fm_slot_t               dec_slot;
	fm_ctl_t                ctl;
	// execute to result
	fm_slot_t               acc_slot;
	logic signed [op_w-1:0] ch_done;
	logic [1:0]             rl_done;

	fm_slot_sequencer fm_slot_sequencer_inst (
		.clk         (clk),
		.rst         (rst),
		.clk_en      (clk_en),
		.slot        (seq_slot),
		.frame_start ()
	);

	fm_sum_decode fm_sum_decode_inst (
		.clk      (clk),
		.rst      (rst),
		.clk_en   (clk_en),
		.cfg_we   (cfg_we),
		.cfg_ch   (cfg_ch),
		.cfg_data (cfg_data),
		.slot     (seq_slot),
		.ctl      (ctl),
		.slot_out (dec_slot)
	);

	fm_channel_acc fm_channel_acc_inst (
		.clk       (clk),
		.rst       (rst),
		.clk_en    (clk_en),
		.slot      (dec_slot),
		.ctl       (ctl),
		.op_result (op_result),
		.pcm       (pcm),
		.ch_done   (ch_done),
		.rl_done   (rl_done),
		.slot_out  (acc_slot)
	);

	fm_output_mixer fm_output_mixer_inst (
		.clk        (clk),
		.rst        (rst),
		.clk_en     (clk_en),
		.slot       (acc_slot),
		.ch_done    (ch_done),
		.rl_done    (rl_done),
		.left       (left),
		.right      (right),
		.sample     (sample),
		.mux_left   (mux_left),
		.mux_right  (mux_right),
		.mux_sample (mux_sample)
	);

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clk,
	output logic rst
);

	// period of 100
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// rst held over the first two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== testbench/tb_fm_acc.sv ====
module tb_fm_acc;
	import fm_acc_pkg::*;

	logic                    clk;
	logic                    rst;
	logic                    clk_en;
	logic signed [op_w-1:0]  op_result;
	logic [op_w-1:0]         pcm;
	logic                    cfg_we;
	logic [2:0]              cfg_ch;
	fm_cfg_u                 cfg_data;
	logic signed [mix_w-1:0] left;
	logic signed [mix_w-1:0] right;
	logic                    sample;
	logic [op_w-1:0]         mux_left;
	logic [op_w-1:0]         mux_right;
	logic                    mux_sample;

	// what the host has written, per channel
	fm_cfg_u                 cfg_model [num_ch];
	integer                  seed;
	// random clk_en drops when set
	bit                      en_random;
	int                      errors;
	int                      failed;
	int                      tests;
	// error count at the start of the running test
	int                      mark;

	tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst(rst));

	fm_acc_top fm_acc_top_inst (.*);

	// pan bits, pcm view only on channel 6 in pcm mode
	function automatic logic [1:0] pan_of(input int ch);
		if ((ch == num_ch - 1) && cfg_model[ch].pcm.pcm_mode) begin
			return cfg_model[ch].pcm.rl;
		end
		return cfg_model[ch].fm.rl;
	endfunction

	// channel sum: carriers times the held operator, limited or wrapped
	function automatic logic signed [op_w-1:0] chan_value(input int ch);
		int carriers;
		int full;
		if ((ch == num_ch - 1) && cfg_model[ch].pcm.pcm_mode) begin
			// offset binary, 256 means zero
			full = int'(pcm) - 256;
			return full[op_w-1:0];
		end
		case (cfg_model[ch].fm.alg)
			3'd4:       carriers = 2;
			3'd5, 3'd6: carriers = 3;
			3'd7:       carriers = 4;
			default:    carriers = 1;
		endcase
		full = carriers * int'(op_result);
		if (cfg_model[ch].fm.limiter_en) begin
			full = (full > 255) ? 255 : ((full < -256) ? -256 : full);
		end
		// without limiter only the low nine bits survive
		return full[op_w-1:0];
	endfunction

	// side 1 is left, side 0 right
	function automatic logic signed [mix_w-1:0] mix_of(input bit side);
		int         acc;
		logic [1:0] pan;
		acc = 0;
		for (int c = 0; c < num_ch; c++) begin
			pan = pan_of(c);
			if (pan[side]) begin
				acc += int'(chan_value(c));
			end
		end
		return acc[mix_w-1:0];
	endfunction

	function automatic fm_cfg_u fm_word(input logic [1:0] rl, input int alg, input bit lim,
		input bit pcm_on);
		fm_cfg_u w;
		w               = '0;
		w.fm.rl         = rl;
		w.fm.alg        = 3'(alg);
		w.fm.limiter_en = lim;
		w.fm.pcm_mode   = pcm_on;
		return w;
	endfunction

	task automatic drive_enable();
		if (en_random) begin
			// roughly one cycle in four is dropped
			clk_en <= (($random(seed) & 3) != 0);
		end else begin
			clk_en <= 1'b1;
		end
	endtask

	// drive on the rising edge, look at outputs on the falling one
	task automatic tick();
		@(posedge clk);
		cfg_we <= 1'b0;
		drive_enable();
		@(negedge clk);
	endtask

	task automatic write_cfg(input int ch, input fm_cfg_u word);
		@(posedge clk);
		cfg_we   <= 1'b1;
		cfg_ch   <= 3'(ch);
		cfg_data <= word;
		drive_enable();
		@(negedge clk);
		cfg_model[ch] = word;
	endtask

	task automatic set_operands(input logic signed [op_w-1:0] v, input logic [op_w-1:0] p);
		@(posedge clk);
		op_result <= v;
		pcm       <= p;
		cfg_we    <= 1'b0;
		drive_enable();
		@(negedge clk);
	endtask

	task automatic expect_equal(input string name, input int expected, input int actual);
		assert (actual == expected)
		else begin
			$display("ERR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic wait_samples(input int count);
		int seen;
		int cycles;
		seen   = 0;
		cycles = 0;
		while ((seen < count) && (cycles < 600)) begin
			tick();
			cycles++;
			if (sample) begin
				seen++;
			end
		end
		assert (seen == count)
		else begin
			$display("timeout at t=%0t, saw %0d of %0d sample pulses", $time, seen, count);
			errors++;
		end
	endtask

	// third pulse after a change carries only new sums
	task automatic stereo_settled();
		wait_samples(3);
		expect_equal("left", int'(mix_of(1'b1)), int'(left));
		expect_equal("right", int'(mix_of(1'b0)), int'(right));
	endtask

	// each mux pulse must show some channel's gated value
	task automatic scan_mux(input int count);
		int                     seen;
		int                     cycles;
		bit                     found;
		logic signed [op_w-1:0] val;
		logic [1:0]             pan;
		seen   = 0;
		cycles = 0;
		while ((seen < count) && (cycles < 600)) begin
			tick();
			cycles++;
			if (mux_sample) begin
				seen++;
				found = 1'b0;
				for (int c = 0; c < num_ch; c++) begin
					val = chan_value(c);
					pan = pan_of(c);
					if ((mux_left == (pan[1] ? val : '0)) &&
						(mux_right == (pan[0] ? val : '0))) begin
						found = 1'b1;
					end
				end
				assert (found)
				else begin
					$display("ERR t=%0t mux_left/mux_right expected a channel value actual %0d/%0d",
						$time, mux_left, mux_right);
					errors++;
				end
			end
		end
		assert (seen == count)
		else begin
			$display("timeout at t=%0t, saw %0d of %0d mux pulses", $time, seen, count);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == mark) begin
			$display("test %s: pass", name);
		end else begin
			failed++;
			$display("test %s: FAIL, %0d errors", name, errors - mark);
		end
		mark = errors;
	endtask

	initial begin
		int      r;
		int      n;
		fm_cfg_u word;
		clk_en    = 1'b1;
		op_result = '0;
		pcm       = '0;
		cfg_we    = 1'b0;
		cfg_ch    = '0;
		cfg_data  = '0;
		seed      = 32'hd38566f7;
		en_random = 1'b0;
		errors    = 0;
		failed    = 0;
		tests     = 0;
		mark      = 0;
		for (int c = 0; c < num_ch; c++) begin
			cfg_model[c] = '0;
		end

		// quiet outputs through the first frame after reset
		n = 0;
		while (rst && (n < 20)) begin
			tick();
			n++;
		end
		assert (!rst)
		else begin
			$display("timeout, reset was never released");
			errors++;
		end
		repeat (slots_per_frame) begin
			tick();
			assert (!sample && !mux_sample)
			else begin
				$display("sample pulse at t=%0t before the first frame completed", $time);
				errors++;
			end
			expect_equal("left", 0, int'(left));
			expect_equal("right", 0, int'(right));
			expect_equal("mux_left", 0, int'(mux_left));
			expect_equal("mux_right", 0, int'(mux_right));
		end
		end_test("reset");

		// all eight algorithms, every channel panned both ways
		for (int a = 0; a < 8; a++) begin
			r = $random(seed);
			for (int c = 0; c < num_ch; c++) begin
				write_cfg(c, fm_word(2'b11, a, 1'b0, 1'b0));
			end
			set_operands(r[op_w-1:0], '0);
			stereo_settled();
			end_test($sformatf("algorithm %0d", a));
		end

		// large magnitudes both signs, limiter off then on
		for (int s = 0; s < 4; s++) begin
			r = 160 + ($random(seed) & 63);
			if (s[0]) begin
				r = -r;
			end
			for (int c = 0; c < num_ch; c++) begin
				write_cfg(c, fm_word(2'b11, 7, s[1], 1'b0));
			end
			set_operands(r[op_w-1:0], '0);
			stereo_settled();
		end
		end_test("limiter");

		// small v keeps 6v left and 5v right apart
		write_cfg(0, fm_word(2'b11, 0, 1'b0, 1'b0));
		write_cfg(1, fm_word(2'b10, 4, 1'b1, 1'b0));
		write_cfg(2, fm_word(2'b01, 5, 1'b0, 1'b0));
		write_cfg(3, fm_word(2'b00, 7, 1'b0, 1'b0));
		write_cfg(4, fm_word(2'b10, 6, 1'b1, 1'b0));
		write_cfg(5, fm_word(2'b01, 1, 1'b0, 1'b0));
		r = 1 + ($random(seed) & 63);
		set_operands(r[op_w-1:0], '0);
		stereo_settled();
		assert (left != right)
		else begin
			$display("left and right equal at t=%0t under mixed pan", $time);
			errors++;
		end
		// channel 6 switched to pcm
		word              = '0;
		word.pcm.rl       = 2'b11;
		word.pcm.pcm_mode = 1'b1;
		write_cfg(5, word);
		r = $random(seed);
		set_operands(op_result, r[op_w-1:0]);
		stereo_settled();
		// pcm bit on another channel is ignored
		write_cfg(2, fm_word(2'b01, 5, 1'b0, 1'b1));
		stereo_settled();
		end_test("pan and pcm");

		scan_mux(24);
		end_test("mux output");

		en_random = 1'b1;
		r = $random(seed);
		set_operands(r[op_w-1:0], pcm);
		stereo_settled();
		scan_mux(24);
		en_random = 1'b0;
		end_test("clock enable");

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== list.f ====
verilog/fm_acc_pkg.sv
verilog/fm_shift_ring.sv
verilog/fm_slot_sequencer.sv
verilog/fm_sum_decode.sv
verilog/fm_channel_acc.sv
verilog/fm_output_mixer.sv
verilog/fm_acc_top.sv
testbench/tb_clock_gen.sv
testbench/tb_fm_acc.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_fm_acc -f list.f --Mdir obj_dir -o tb_fm_acc
	@out="$$(./obj_dir/tb_fm_acc)"; echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
